/* design/tawas_pkg.sv */
// Tawas fetch shared definitions
// Widths, the instruction word views, opcode tags and the
// register offsets of the AXI4-Lite control block
`default_nettype none

package tawas_pkg;

  localparam int PC_W = 24;
  localparam int AU_OP_W = 6;
  localparam int LS_TYPE_W = 2;

  // Control word tags and the branch prefix
  localparam logic [3:0] TAG_JUMP = 4'hF;
  localparam logic [3:0] TAG_IMM = 4'hE;
  localparam logic [2:0] PFX_BRANCH = 3'b110;

  // Control view of an instruction word
  typedef struct packed {
    logic [3:0] tag;
    logic [3:0] link;
    logic [PC_W-1:0] target;
  } tawas_ctl_t;

  // Slot pair view, lower slot issues first
  typedef struct packed {
    logic [1:0] pfx;
    logic [14:0] hi;
    logic [14:0] lo;
  } tawas_pair_t;

  typedef union packed {
    tawas_ctl_t ctl;
    tawas_pair_t pair;
  } tawas_instr_u;

  localparam logic [31:0] REG_CTRL = 32'h00;
  localparam logic [31:0] REG_IMEM_ADDR = 32'h04;
  localparam logic [31:0] REG_IMEM_DATA = 32'h08;
  localparam logic [31:0] REG_PC0 = 32'h0C;
  localparam logic [31:0] REG_PC1 = 32'h10;

endpackage

`default_nettype wire

/* design/tawas_ifs.sv */
// Tawas fetch interfaces
// AU op bundle, LS op bundle and the link register port
`timescale 1ns/1ps
`default_nettype none

interface au_op_if;
  logic vld;
  logic [tawas_pkg::AU_OP_W-1:0] op;
  logic [3:0] ra;
  logic [3:0] rb;
  logic imm_vld;
  logic [31:0] imm;

  modport src (output vld, op, ra, rb, imm_vld, imm);
endinterface

interface ls_op_if;
  logic vld;
  logic store;
  logic [tawas_pkg::LS_TYPE_W-1:0] op_type;
  logic [3:0] ptr;
  logic [3:0] offset;
  logic [3:0] reg_id;

  modport src (output vld, store, op_type, ptr, offset, reg_id);
endinterface

interface link_if;
  logic store;
  logic [3:0] store_reg;
  logic [tawas_pkg::PC_W-1:0] pc;
  logic [3:0] load_reg;
  logic [tawas_pkg::PC_W-1:0] rtn;

  modport fetch (output store, store_reg, pc, load_reg, input rtn);
  modport regs (input store, store_reg, pc, load_reg, output rtn);
endinterface

`default_nettype wire

/* design/tawas_irom.sv */
// Tawas instruction memory
// Combinational read for fetch, clocked write from the register block
`timescale 1ns/1ps
`default_nettype none

module tawas_irom #(
  parameter int IMEM_DEPTH = 256,
  localparam int AW = $clog2(IMEM_DEPTH)
) (
  input  logic CLK,
  input  logic [tawas_pkg::PC_W-1:0] iaddr,
  output logic [31:0] idata,
  input  logic we,
  input  logic [AW-1:0] waddr,
  input  logic [31:0] wdata
);

  logic [31:0] mem [IMEM_DEPTH];

  always_ff @(posedge CLK)
    if (we)
      mem[waddr] <= wdata;

  // Upper PC bits alias onto the array
  assign idata = mem[iaddr[AW-1:0]];

endmodule

`default_nettype wire

/* design/tawas_link_regs.sv */
// Tawas link register file
// Sixteen return address registers, written on a call and
// read combinationally for a return
`timescale 1ns/1ps
`default_nettype none

module tawas_link_regs (
  input logic CLK,
  input logic RST,
  link_if.regs link
);

  logic [15:0][tawas_pkg::PC_W-1:0] lr;

  always_ff @(posedge CLK or posedge RST)
    if (RST)
      lr <= '0;
    else if (link.store)
      lr[link.store_reg] <= link.pc;

  assign link.rtn = lr[link.load_reg];

endmodule

`default_nettype wire

/* design/tawas_ctrl_regs.sv */
// Tawas control registers
// AXI4-Lite slave with the run bit, the instruction memory load
// pointer and data port, and read back of both slice PCs
`timescale 1ns/1ps
`default_nettype none

module tawas_ctrl_regs #(
  parameter int IMEM_DEPTH = 256,
  localparam int AW = $clog2(IMEM_DEPTH)
) (
  input  logic CLK,
  input  logic RST,
  input  logic [31:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [31:0] wdata,
  input  logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input  logic bready,
  input  logic [31:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input  logic rready,
  output logic run,
  output logic imem_we,
  output logic [AW-1:0] imem_waddr,
  output logic [31:0] imem_wdata,
  input  logic [tawas_pkg::PC_W-1:0] pc0,
  input  logic [tawas_pkg::PC_W-1:0] pc1
);

  logic wr_rdy;
  logic [AW-1:0] ptr;
  logic [31:0] rd_mux;

  // Write channel, address and data accepted together
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      wr_rdy <= 1'b0;
      bvalid <= 1'b0;
    end
    else
    begin
      wr_rdy <= awvalid && wvalid && !wr_rdy && !bvalid;
      if (wr_rdy)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end

  assign awready = wr_rdy;
  assign wready = wr_rdy;
  assign bresp = 2'b00;

  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      run <= 1'b0;
      ptr <= '0;
    end
    else if (wr_rdy)
    begin
      if (awaddr == tawas_pkg::REG_CTRL)
        run <= wdata[0];
      else if (awaddr == tawas_pkg::REG_IMEM_ADDR)
        ptr <= wdata[AW-1:0];
      else if (awaddr == tawas_pkg::REG_IMEM_DATA)
        ptr <= ptr + AW'(1);
    end

  // Data port store at the load pointer
  assign imem_we = wr_rdy && (awaddr == tawas_pkg::REG_IMEM_DATA);
  assign imem_waddr = ptr;
  assign imem_wdata = wdata;

  always_comb
  begin
    rd_mux = 32'd0;
    if (araddr == tawas_pkg::REG_CTRL)
      rd_mux = {31'd0, run};
    else if (araddr == tawas_pkg::REG_IMEM_ADDR)
      rd_mux = 32'(ptr);
    else if (araddr == tawas_pkg::REG_PC0)
      rd_mux = 32'(pc0);
    else if (araddr == tawas_pkg::REG_PC1)
      rd_mux = 32'(pc1);
  end

  // Read channel, data follows arready by one cycle
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      arready <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      arready <= arvalid && !arready && !rvalid;
      if (arready)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end

  always_ff @(posedge CLK)
    if (arready)
      rdata <= rd_mux;

  assign rresp = 2'b00;

endmodule

`default_nettype wire

/* design/tawas_fetch.sv */
// Tawas instruction fetch
// Two slices share the fetch path and alternate every clock.
// Jumps, calls, returns, relative branches and immediate prefixes
// are executed here; other words are split into AU and LS ops.
// Slice 0 starts at PC 0, slice 1 at PC 1
`timescale 1ns/1ps
`default_nettype none

module tawas_fetch (
  input  logic CLK,
  input  logic RST,
  input  logic run,
  output logic [tawas_pkg::PC_W-1:0] iaddr,
  input  tawas_pkg::tawas_instr_u idata,
  input  logic [15:0] au_flags,
  output logic slice,
  output logic [tawas_pkg::PC_W-1:0] pc0,
  output logic [tawas_pkg::PC_W-1:0] pc1,
  au_op_if.src au,
  ls_op_if.src ls,
  link_if.fetch link
);

  localparam int PC_W = tawas_pkg::PC_W;

  logic [31:0] w;
  logic active;
  logic is_jump;
  logic is_branch;
  logic [3:0] cond_sel;
  logic cond_true;
  logic instr_vld;
  logic cur_slice;
  logic other_slice;
  logic [1:0][PC_W-1:0] pc_q;
  logic [1:0] series_q;
  logic [1:0][27:0] imm_q;
  logic [PC_W-1:0] pc_cur;
  logic [PC_W-1:0] pc_inc;
  logic [PC_W-1:0] pc_next;
  logic store_en;
  logic [3:0] store_sel;
  logic au_upper;
  logic ls_upper;
  logic [14:0] au_slot;
  logic [14:0] ls_slot;

  assign w = idata;
  assign active = run & instr_vld;
  assign is_jump = idata.ctl.tag == tawas_pkg::TAG_JUMP;
  assign is_branch = w[31:29] == tawas_pkg::PFX_BRANCH;
  assign other_slice = ~cur_slice;

  // Condition flag select, flag 0 for anything but a branch word
  always_comb
  begin
    cond_sel = 4'd0;
    if (is_branch)
    begin
      if (w[27:26] == 2'b10)
        cond_sel = w[25:22];
      else if (!w[27])
        cond_sel = w[26:23];
    end
  end

  assign cond_true = au_flags[cond_sel];

  assign pc_cur = pc_q[cur_slice];
  assign pc_inc = pc_cur + PC_W'(1);

  // Next PC and link store for the word on idata
  always_comb
  begin
    pc_next = pc_inc;
    store_en = 1'b0;
    store_sel = 4'd0;
    if (cond_true)
    begin
      if (is_jump)
      begin
        pc_next = idata.ctl.target;
        store_en = idata.ctl.link != 4'd0;
        store_sel = idata.ctl.link;
      end
      else if (is_branch)
      begin
        if (!w[27])
        begin
          // Return, the return PC goes to another link register
          pc_next = link.rtn;
          store_en = 1'b1;
          store_sel = w[22:19];
        end
        else if (w[26])
          pc_next = pc_cur + {{(PC_W-11){w[25]}}, w[25:15]};
        else
          pc_next = pc_cur + {{(PC_W-7){w[21]}}, w[21:15]};
      end
    end
  end

  assign link.store = active & store_en;
  assign link.store_reg = store_sel;
  assign link.pc = pc_inc;
  assign link.load_reg = (w[31:30] == 2'b11) ? w[18:15] : 4'd0;

  // Slice sequencing, the first run cycle only loads slice 1's address
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      instr_vld <= 1'b0;
      cur_slice <= 1'b0;
      iaddr <= '0;
    end
    else if (!run)
    begin
      instr_vld <= 1'b0;
      cur_slice <= 1'b0;
      iaddr <= '0;
    end
    else
    begin
      instr_vld <= 1'b1;
      cur_slice <= other_slice;
      iaddr <= pc_q[other_slice];
    end

  // Per-slice PC and pair word series state
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      pc_q[0] <= PC_W'(0);
      pc_q[1] <= PC_W'(1);
      series_q <= 2'b00;
    end
    else if (!run)
    begin
      pc_q[0] <= PC_W'(0);
      pc_q[1] <= PC_W'(1);
      series_q <= 2'b00;
    end
    else if (instr_vld)
    begin
      if (w[31] || series_q[cur_slice])
      begin
        pc_q[cur_slice] <= pc_next;
        series_q[cur_slice] <= 1'b0;
      end
      else
        series_q[cur_slice] <= 1'b1;
    end

  // Immediate prefix hold per slice
  always_ff @(posedge CLK or posedge RST)
    if (RST)
      imm_q <= '0;
    else if (active && (idata.ctl.tag == tawas_pkg::TAG_IMM))
      imm_q[cur_slice] <= {idata.ctl.link, idata.ctl.target};

  // Upper slot on the second turn of a pair word
  assign au_upper = series_q[cur_slice];
  assign ls_upper = au_upper | (w[31:30] == 2'b10);
  assign au_slot = au_upper ? idata.pair.hi : idata.pair.lo;
  assign ls_slot = ls_upper ? idata.pair.hi : idata.pair.lo;

  assign au.vld = active & ((w[31:30] == 2'b00) | (w[31:30] == 2'b10) | (w[31:28] == 4'b1100));
  assign au.op = au_slot[13:8];
  assign au.ra = au_slot[7:4];
  assign au.rb = au_slot[3:0];
  assign au.imm_vld = au_slot[14];
  assign au.imm = {imm_q[cur_slice], au_slot[7:4]};

  assign ls.vld = active & ((w[31:30] == 2'b01) | (w[31:30] == 2'b10) | (w[31:28] == 4'b1101));
  assign ls.store = ls_slot[14];
  assign ls.op_type = ls_slot[13:12];
  assign ls.ptr = ls_slot[11:8];
  assign ls.offset = ls_slot[7:4];
  assign ls.reg_id = ls_slot[3:0];

  assign slice = cur_slice;
  assign pc0 = pc_q[0];
  assign pc1 = pc_q[1];

endmodule

`default_nettype wire

/* design/tawas_fetch_top.sv */
// Tawas fetch subsystem top level
// AXI4-Lite control block, instruction memory, fetch unit and
// link registers; AU and LS ops leave on plain ports
`timescale 1ns/1ps
`default_nettype none

module tawas_fetch_top #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic CLK,
  input  logic RST,
  input  logic [31:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [31:0] wdata,
  input  logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input  logic bready,
  input  logic [31:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic [31:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input  logic rready,
  input  logic [15:0] au_flags,
  output logic slice,
  output logic au_op_vld,
  output logic [tawas_pkg::AU_OP_W-1:0] au_op,
  output logic [3:0] au_op_ra,
  output logic [3:0] au_op_rb,
  output logic au_op_imm_vld,
  output logic [31:0] au_op_imm,
  output logic ls_op_vld,
  output logic ls_op_store,
  output logic [tawas_pkg::LS_TYPE_W-1:0] ls_op_type,
  output logic [3:0] ls_op_ptr,
  output logic [3:0] ls_op_offset,
  output logic [3:0] ls_op_reg
);

  localparam int AW = $clog2(IMEM_DEPTH);

  logic run;
  logic imem_we;
  logic [AW-1:0] imem_waddr;
  logic [31:0] imem_wdata;
  logic [tawas_pkg::PC_W-1:0] iaddr;
  logic [31:0] idata;
  logic [tawas_pkg::PC_W-1:0] pc0;
  logic [tawas_pkg::PC_W-1:0] pc1;

  au_op_if au_op_bus ();
  ls_op_if ls_op_bus ();
  link_if link_bus ();

  tawas_ctrl_regs #(.IMEM_DEPTH(IMEM_DEPTH)) i_ctrl_regs (
    .CLK(CLK), .RST(RST),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .run(run), .imem_we(imem_we), .imem_waddr(imem_waddr),
    .imem_wdata(imem_wdata), .pc0(pc0), .pc1(pc1)
  );

  tawas_irom #(.IMEM_DEPTH(IMEM_DEPTH)) i_irom (
    .CLK(CLK), .iaddr(iaddr), .idata(idata),
    .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata)
  );

  tawas_fetch i_fetch (
    .CLK(CLK), .RST(RST), .run(run),
    .iaddr(iaddr), .idata(idata), .au_flags(au_flags),
    .slice(slice), .pc0(pc0), .pc1(pc1),
    .au(au_op_bus.src), .ls(ls_op_bus.src), .link(link_bus.fetch)
  );

  tawas_link_regs i_link_regs (
    .CLK(CLK), .RST(RST), .link(link_bus.regs)
  );

  assign au_op_vld = au_op_bus.vld;
  assign au_op = au_op_bus.op;
  assign au_op_ra = au_op_bus.ra;
  assign au_op_rb = au_op_bus.rb;
  assign au_op_imm_vld = au_op_bus.imm_vld;
  assign au_op_imm = au_op_bus.imm;

  assign ls_op_vld = ls_op_bus.vld;
  assign ls_op_store = ls_op_bus.store;
  assign ls_op_type = ls_op_bus.op_type;
  assign ls_op_ptr = ls_op_bus.ptr;
  assign ls_op_offset = ls_op_bus.offset;
  assign ls_op_reg = ls_op_bus.reg_id;

endmodule

`default_nettype wire

/* verif/tawas_fetch_model.svh */
// Tawas fetch reference model
// Tracks PC, pair series state and immediate hold per slice, the
// link registers and the run bit, and predicts the op ports
`ifndef TAWAS_FETCH_MODEL_SVH
`define TAWAS_FETCH_MODEL_SVH

localparam int PC_W = tawas_pkg::PC_W;
localparam int PROG_LEN = 64;

logic [31:0] prog_m [PROG_LEN];
logic [PC_W-1:0] pc_m [2];
logic [1:0] series_m;
logic [27:0] imm_m [2];
logic [PC_W-1:0] lr_m [16];
logic run_m;
logic run_next_m;
logic vld_m;
logic slice_m;
logic [7:0] ptr_m;

task automatic stop_run();
  $display("TEST FAILED");
  $fatal(1);
endtask

task automatic check_val(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
  if (got !== expected)
  begin
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
    stop_run();
  end
endtask

task automatic reset_model();
  pc_m[0] = 24'd0;
  pc_m[1] = 24'd1;
  series_m = 2'b00;
  for (int i = 0; i < 16; i++)
    lr_m[i] = '0;
  imm_m[0] = '0;
  imm_m[1] = '0;
  run_m = 1'b0;
  run_next_m = 1'b0;
  vld_m = 1'b0;
  slice_m = 1'b0;
  ptr_m = 8'd0;
endtask

// Register contents as the AXI read mux sees them this cycle
function automatic logic [31:0] reg_value(input logic [31:0] a);
  logic [31:0] v;
  v = 32'd0;
  if (a == tawas_pkg::REG_CTRL)
    v = {31'd0, run_m};
  else if (a == tawas_pkg::REG_IMEM_ADDR)
    v = {24'd0, ptr_m};
  else if (a == tawas_pkg::REG_PC0)
    v = {8'd0, pc_m[0]};
  else if (a == tawas_pkg::REG_PC1)
    v = {8'd0, pc_m[1]};
  return v;
endfunction

// Expected op ports for the word the current slice is on
task automatic check_fetch();
  logic [31:0] w;
  logic active;
  logic upper;
  logic [14:0] au_s;
  logic [14:0] ls_s;
  logic au_v;
  logic ls_v;
  w = prog_m[pc_m[slice_m][5:0]];
  active = run_m && vld_m;
  upper = series_m[slice_m];
  au_s = upper ? w[29:15] : w[14:0];
  ls_s = (upper || w[31:30] == 2'b10) ? w[29:15] : w[14:0];
  au_v = active && (w[31:30] == 2'b00 || w[31:30] == 2'b10 || w[31:28] == 4'b1100);
  ls_v = active && (w[31:30] == 2'b01 || w[31:30] == 2'b10 || w[31:28] == 4'b1101);
  check_val("slice", 32'(slice), 32'(slice_m));
  check_val("au_op_vld", 32'(au_op_vld), 32'(au_v));
  check_val("ls_op_vld", 32'(ls_op_vld), 32'(ls_v));
  if (au_v)
  begin
    check_val("au_op", 32'(au_op), 32'(au_s[13:8]));
    check_val("au_op_ra", 32'(au_op_ra), 32'(au_s[7:4]));
    check_val("au_op_rb", 32'(au_op_rb), 32'(au_s[3:0]));
    check_val("au_op_imm_vld", 32'(au_op_imm_vld), 32'(au_s[14]));
    check_val("au_op_imm", au_op_imm, {imm_m[slice_m], au_s[7:4]});
  end
  if (ls_v)
  begin
    check_val("ls_op_store", 32'(ls_op_store), 32'(ls_s[14]));
    check_val("ls_op_type", 32'(ls_op_type), 32'(ls_s[13:12]));
    check_val("ls_op_ptr", 32'(ls_op_ptr), 32'(ls_s[11:8]));
    check_val("ls_op_offset", 32'(ls_op_offset), 32'(ls_s[7:4]));
    check_val("ls_op_reg", 32'(ls_op_reg), 32'(ls_s[3:0]));
  end
endtask

// State after the next rising edge
task automatic advance_model();
  logic [31:0] w;
  logic s;
  logic [PC_W-1:0] pc;
  logic [PC_W-1:0] inc;
  logic [PC_W-1:0] nxt;
  logic [3:0] sel;
  s = slice_m;
  if (!run_m)
  begin
    vld_m = 1'b0;
    slice_m = 1'b0;
    pc_m[0] = 24'd0;
    pc_m[1] = 24'd1;
    series_m = 2'b00;
  end
  else
  begin
    if (vld_m)
    begin
      w = prog_m[pc_m[s][5:0]];
      pc = pc_m[s];
      inc = pc + 24'd1;
      nxt = inc;
      sel = 4'd0;
      if (w[31:29] == 3'b110)
      begin
        if (!w[27])
          sel = w[26:23];
        else if (!w[26])
          sel = w[25:22];
      end
      if (au_flags[sel])
      begin
        if (w[31:28] == 4'hF)
        begin
          nxt = w[23:0];
          if (w[27:24] != 4'd0)
            lr_m[w[27:24]] = inc;
        end
        else if (w[31:29] == 3'b110)
        begin
          // Return reads the old link value before its own store
          if (!w[27])
          begin
            nxt = lr_m[w[18:15]];
            lr_m[w[22:19]] = inc;
          end
          else if (w[26])
            nxt = pc + {{13{w[25]}}, w[25:15]};
          else
            nxt = pc + {{17{w[21]}}, w[21:15]};
        end
      end
      if (w[31:28] == 4'hE)
        imm_m[s] = w[27:0];
      if (w[31] || series_m[s])
      begin
        pc_m[s] = nxt;
        series_m[s] = 1'b0;
      end
      else
        series_m[s] = 1'b1;
    end
    vld_m = 1'b1;
    slice_m = ~slice_m;
  end
  run_m = run_next_m;
endtask

`endif

/* verif/tb_tawas_fetch.sv */
// Testbench for the Tawas fetch subsystem
// Loads a random program over AXI4-Lite, runs both slices with
// random AU flags and compares every cycle with a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_tawas_fetch;

  // About 200 load cycles plus 1500 run cycles and a margin
  localparam int MAX_CYCLES = 3000;

  logic CLK;
  logic RST;
  logic [31:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [31:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [15:0] au_flags;
  logic slice;
  logic au_op_vld;
  logic [tawas_pkg::AU_OP_W-1:0] au_op;
  logic [3:0] au_op_ra;
  logic [3:0] au_op_rb;
  logic au_op_imm_vld;
  logic [31:0] au_op_imm;
  logic ls_op_vld;
  logic ls_op_store;
  logic [tawas_pkg::LS_TYPE_W-1:0] ls_op_type;
  logic [3:0] ls_op_ptr;
  logic [3:0] ls_op_offset;
  logic [3:0] ls_op_reg;

  int cyc;
  logic snap_pending;
  logic [31:0] snap_addr;
  logic [31:0] rd_expect;

  `include "tawas_fetch_model.svh"

  tawas_fetch_top #(.IMEM_DEPTH(256)) i_tawas_fetch_top (
    .CLK(CLK), .RST(RST),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .au_flags(au_flags), .slice(slice),
    .au_op_vld(au_op_vld), .au_op(au_op), .au_op_ra(au_op_ra),
    .au_op_rb(au_op_rb), .au_op_imm_vld(au_op_imm_vld), .au_op_imm(au_op_imm),
    .ls_op_vld(ls_op_vld), .ls_op_store(ls_op_store), .ls_op_type(ls_op_type),
    .ls_op_ptr(ls_op_ptr), .ls_op_offset(ls_op_offset), .ls_op_reg(ls_op_reg)
  );

  always #2 CLK = ~CLK;

  // Outputs are compared on the falling edge where they are settled
  task automatic sample_cycle();
    @(negedge CLK);
    check_fetch();
    if (snap_pending)
    begin
      rd_expect = reg_value(snap_addr);
      snap_pending = 1'b0;
    end
    advance_model();
    cyc++;
    if (cyc >= MAX_CYCLES)
    begin
      $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
      stop_run();
    end
  endtask

  // Flag 15 stays set so the two closing branches are always taken
  task automatic drive_edge();
    @(posedge CLK);
    if (cyc % 16 == 0)
      au_flags <= 16'($urandom) | 16'h8000;
  endtask

  task automatic run_cycles(input int n);
    repeat (n)
    begin
      sample_cycle();
      drive_edge();
    end
  endtask

  task automatic axi_write(input logic [31:0] a, input logic [31:0] d);
    awaddr <= a;
    wdata <= d;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    sample_cycle();
    check_val("awready", 32'(awready), 32'd0);
    drive_edge();
    if (a == tawas_pkg::REG_CTRL)
      run_next_m = d[0];
    else if (a == tawas_pkg::REG_IMEM_ADDR)
      ptr_m = d[7:0];
    else if (a == tawas_pkg::REG_IMEM_DATA)
      ptr_m = ptr_m + 8'd1;
    sample_cycle();
    check_val("awready", 32'(awready), 32'd1);
    check_val("wready", 32'(wready), 32'd1);
    drive_edge();
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    sample_cycle();
    check_val("awready", 32'(awready), 32'd0);
    check_val("bvalid", 32'(bvalid), 32'd1);
    check_val("bresp", 32'(bresp), 32'd0);
    drive_edge();
  endtask

  task automatic axi_read(input logic [31:0] a, input string name);
    araddr <= a;
    arvalid <= 1'b1;
    sample_cycle();
    check_val("arready", 32'(arready), 32'd0);
    drive_edge();
    snap_addr = a;
    snap_pending = 1'b1;
    sample_cycle();
    check_val("arready", 32'(arready), 32'd1);
    drive_edge();
    arvalid <= 1'b0;
    sample_cycle();
    check_val("rvalid", 32'(rvalid), 32'd1);
    check_val("rresp", 32'(rresp), 32'd0);
    check_val(name, rdata, rd_expect);
    drive_edge();
  endtask

  // Random program word from the decode rules
  // The last two branch back on flag 15 so PCs stay in range
  function automatic logic [31:0] random_word(input int addr);
    logic [31:0] w;
    logic [5:0] t;
    int kind;
    w = $urandom;
    t = 6'($urandom_range(0, PROG_LEN - 1));
    kind = (addr >= PROG_LEN - 2) ? 9 : int'($urandom_range(0, 9));
    case (kind)
      0, 1: w[31:30] = 2'b00;
      2: w[31:30] = 2'b01;
      3, 4: w[31:30] = 2'b10;
      5: w[31:28] = 4'hE;
      6:
      begin
        w[31:28] = 4'hF;
        w[23:0] = 24'(t);
      end
      7:
      begin
        w[31:29] = 3'b110;
        w[27] = 1'b0;
      end
      8:
      begin
        w[31:29] = 3'b110;
        w[27:26] = 2'b11;
        w[25:15] = 11'(int'(t) - addr);
      end
      default:
      begin
        w[31:29] = 3'b110;
        w[27:26] = 2'b10;
        w[21:15] = 7'(int'(t) - addr);
        if (addr >= PROG_LEN - 2)
          w[25:22] = 4'hF;
      end
    endcase
    return w;
  endfunction

  initial
  begin
    CLK = 1'b0;
    RST = 1'b1;
    awaddr = 32'd0;
    awvalid = 1'b0;
    wdata = 32'd0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = 32'd0;
    arvalid = 1'b0;
    rready = 1'b1;
    au_flags = 16'h8000;
    cyc = 0;
    snap_pending = 1'b0;
    snap_addr = 32'd0;
    rd_expect = 32'd0;
    reset_model();
    void'($urandom(32'h6ff9ff14));
    for (int i = 0; i < PROG_LEN; i++)
      prog_m[i] = random_word(i);

    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // Idle with run low, then load the program
    run_cycles(8);
    axi_write(tawas_pkg::REG_IMEM_ADDR, 32'd0);
    for (int i = 0; i < PROG_LEN; i++)
      axi_write(tawas_pkg::REG_IMEM_DATA, prog_m[i]);
    axi_read(tawas_pkg::REG_IMEM_ADDR, "rdata imem_addr");
    axi_read(tawas_pkg::REG_CTRL, "rdata ctrl");

    axi_write(tawas_pkg::REG_CTRL, 32'd1);
    axi_read(tawas_pkg::REG_CTRL, "rdata ctrl");
    repeat (6)
    begin
      run_cycles(240);
      axi_read(tawas_pkg::REG_PC0, "rdata pc0");
      axi_read(tawas_pkg::REG_PC1, "rdata pc1");
    end

    // Stopping returns both slices to their start PCs
    axi_write(tawas_pkg::REG_CTRL, 32'd0);
    axi_read(tawas_pkg::REG_CTRL, "rdata ctrl");
    axi_read(tawas_pkg::REG_PC0, "rdata pc0");
    axi_read(tawas_pkg::REG_PC1, "rdata pc1");
    run_cycles(4);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verif
design/tawas_pkg.sv
design/tawas_ifs.sv
design/tawas_irom.sv
design/tawas_link_regs.sv
design/tawas_ctrl_regs.sv
design/tawas_fetch.sv
design/tawas_fetch_top.sv
verif/tb_tawas_fetch.sv

/* Makefile */
TOP = tb_tawas_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
